// File: aes_pkg.sv
// aes shared types and constants
`default_nettype none

package aes_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // full block, used for key, state and ciphertext
    // byte S(r,c) sits at [127-8*(4c+r) -: 8], word w[0] at [127:96]
    typedef logic [127:0] aes_block_t;

    // one column word w[i]
    typedef logic [31:0] aes_word_t;

    // one state byte
    typedef logic [7:0] aes_byte_t;

    // round number, 0 to 10
    typedef logic [3:0] aes_round_t;

    //////////////////////////////
    // constants
    //////////////////////////////

    // Nr for a 128 bit key
    localparam aes_round_t AES_NUM_ROUNDS = 4'd10;

    // first round constant, doubled every key step
    localparam aes_byte_t AES_RCON_INIT = 8'h01;

    // control states of the iterative engine
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE
    } aes_ctrl_t;

    // multiply by x in GF(2^8), reduced by the AES polynomial
    // shared by MixColumns and the round constant update
    function automatic aes_byte_t aes_xtime(input aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[6:0], 1'b0};
        // top bit falling out means reduce by 1b
        return b[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

endpackage

`default_nettype wire

// File: aes_sbox.sv
// aes forward s-box
`timescale 1ns/1ps
`default_nettype none

module aes_sbox (
    input  aes_pkg::aes_byte_t a,
    output aes_pkg::aes_byte_t y
);

    //////////////////////////////
    // substitution table
    //////////////////////////////

    // one table row per upper nibble, 16 bytes each
    // entry for lower nibble 0 is the leftmost byte
    logic [127:0] row;

    always_comb begin
        case (a[7:4])
            4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
            4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
            4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
            4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
            4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
            4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
            4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
            4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
            4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
            4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
            4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
            4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
            4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
            4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
            4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
            4'hf: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
            default: row = '0;
        endcase
    end

    // pick the byte for the lower nibble
    // column 0 is the most significant byte of the row
    assign y = row[127 - 8 * a[3:0] -: 8];

endmodule

`default_nettype wire

// File: aes_key_schedule.sv
// aes-128 round key generator
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                step,
    input  aes_pkg::aes_block_t key,
    output aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t next_round_key
);

    import aes_pkg::*;

    // current round key and its round constant
    aes_block_t key_q;
    aes_byte_t  rcon_q;

    // words of the current key
    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;

    // g() applied to the last word
    aes_word_t rot_word;
    aes_word_t sub_word;
    aes_word_t temp_word;

    // words of the next key
    aes_word_t n0;
    aes_word_t n1;
    aes_word_t n2;
    aes_word_t n3;

    //////////////////////////////
    // expansion step
    //////////////////////////////

    assign {w0, w1, w2, w3} = key_q;

    // RotWord, one byte left
    assign rot_word = {w3[23:0], w3[31:24]};

    // SubWord through four s-boxes
    for (genvar i = 0; i < 4; i++) begin : g_sub_word
        aes_sbox u_sbox (
            .a(rot_word[31 - 8 * i -: 8]),
            .y(sub_word[31 - 8 * i -: 8])
        );
    end

    // rcon only touches the top byte
    assign temp_word = sub_word ^ {rcon_q, 24'h000000};

    // xor chain across the four words
    assign n0 = w0 ^ temp_word;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign next_round_key = {n0, n1, n2, n3};
    assign round_key      = key_q;

    //////////////////////////////
    // registers
    //////////////////////////////

    // round constant, restarts on every start
    always_ff @(posedge clk) begin
        if (!reset) begin
            rcon_q <= AES_RCON_INIT;
        end else if (start) begin
            rcon_q <= AES_RCON_INIT;
        end else if (step) begin
            rcon_q <= aes_xtime(rcon_q);
        end
    end

    // key register
    always_ff @(posedge clk) begin
        if (start) begin
            key_q <= key;
        end else if (step) begin
            key_q <= next_round_key;
        end
    end

endmodule

`default_nettype wire

// File: aes_round.sv
// aes single encryption round
`timescale 1ns/1ps
`default_nettype none

module aes_round (
    input  aes_pkg::aes_block_t state_in,
    input  aes_pkg::aes_block_t round_key,
    input  logic                final_round,
    output aes_pkg::aes_block_t state_out
);

    import aes_pkg::*;

    aes_block_t sub_state;
    aes_block_t shift_state;
    aes_block_t mix_state;

    //////////////////////////////
    // SubBytes
    //////////////////////////////

    // byte i is S(i%4, i/4)
    for (genvar i = 0; i < 16; i++) begin : g_sub_bytes
        aes_sbox u_sbox (
            .a(state_in[127 - 8 * i -: 8]),
            .y(sub_state[127 - 8 * i -: 8])
        );
    end

    //////////////////////////////
    // ShiftRows
    //////////////////////////////

    // row r moves left by r columns
    // S'(r,c) = S(r, (c+r) mod 4)
    for (genvar c = 0; c < 4; c++) begin : g_shift_col
        for (genvar r = 0; r < 4; r++) begin : g_shift_row
            assign shift_state[127 - 8 * (4 * c + r) -: 8] =
                sub_state[127 - 8 * (4 * ((c + r) % 4) + r) -: 8];
        end
    end

    //////////////////////////////
    // MixColumns
    //////////////////////////////

    // each column times the fixed matrix {02 03 01 01}
    for (genvar c = 0; c < 4; c++) begin : g_mix_col
        aes_byte_t s0;
        aes_byte_t s1;
        aes_byte_t s2;
        aes_byte_t s3;
        aes_byte_t x0;
        aes_byte_t x1;
        aes_byte_t x2;
        aes_byte_t x3;

        assign s0 = shift_state[127 - 32 * c -: 8];
        assign s1 = shift_state[119 - 32 * c -: 8];
        assign s2 = shift_state[111 - 32 * c -: 8];
        assign s3 = shift_state[103 - 32 * c -: 8];

        // 02 * s, and 03 * s is xtime(s) ^ s
        assign x0 = aes_xtime(s0);
        assign x1 = aes_xtime(s1);
        assign x2 = aes_xtime(s2);
        assign x3 = aes_xtime(s3);

        assign mix_state[127 - 32 * c -: 8] = x0 ^ x1 ^ s1 ^ s2 ^ s3;
        assign mix_state[119 - 32 * c -: 8] = s0 ^ x1 ^ x2 ^ s2 ^ s3;
        assign mix_state[111 - 32 * c -: 8] = s0 ^ s1 ^ x2 ^ x3 ^ s3;
        assign mix_state[103 - 32 * c -: 8] = x0 ^ s0 ^ s1 ^ s2 ^ x3;
    end

    //////////////////////////////
    // AddRoundKey
    //////////////////////////////

    // last round skips MixColumns
    assign state_out = (final_round ? shift_state : mix_state) ^ round_key;

endmodule

`default_nettype wire

// File: aes_core.sv
// aes-128 iterative encryption core
`timescale 1ns/1ps
`default_nettype none

module aes_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  aes_pkg::aes_block_t key,
    input  aes_pkg::aes_block_t plaintext,
    output logic                done,
    output aes_pkg::aes_block_t ciphertext
);

    import aes_pkg::*;

    // control
    aes_ctrl_t  ctrl_q;
    aes_round_t round_cnt;

    // datapath
    aes_block_t state_q;
    aes_block_t round_out;
    aes_block_t next_key;

    // strobes to the key schedule and round
    logic ks_start;
    logic ks_step;
    logic final_round;

    //////////////////////////////
    // control strobes
    //////////////////////////////

    // load only counts in idle, anything else is dropped
    assign ks_start = (ctrl_q == CTRL_IDLE) && load;

    // one key step per round
    assign ks_step = (ctrl_q == CTRL_RUN);

    // round 10 has no MixColumns
    assign final_round = (round_cnt == AES_NUM_ROUNDS);

    //////////////////////////////
    // key schedule and round
    //////////////////////////////

    // current key stays inside the schedule, the round uses the next one
    aes_key_schedule u_key_schedule (
        .clk           (clk),
        .reset         (reset),
        .start         (ks_start),
        .step          (ks_step),
        .key           (key),
        .round_key     (),
        .next_round_key(next_key)
    );

    aes_round u_round (
        .state_in   (state_q),
        .round_key  (next_key),
        .final_round(final_round),
        .state_out  (round_out)
    );

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (ks_start) begin
            // initial AddRoundKey with the cipher key
            state_q <= plaintext ^ key;
        end else if (ks_step) begin
            state_q <= round_out;
        end
    end

    //////////////////////////////
    // control FSM
    //////////////////////////////

    // idle -> run for 10 rounds -> done for one cycle -> idle
    always_ff @(posedge clk) begin
        if (!reset) begin
            ctrl_q     <= CTRL_IDLE;
            round_cnt  <= '0;
            done       <= 1'b0;
            ciphertext <= '0;
        end else begin
            // done is a single cycle strobe
            done <= 1'b0;
            case (ctrl_q)
                CTRL_IDLE: begin
                    if (load) begin
                        ctrl_q    <= CTRL_RUN;
                        round_cnt <= 4'd1;
                    end
                end
                CTRL_RUN: begin
                    if (final_round) begin
                        // round 10 output is the result
                        ctrl_q     <= CTRL_DONE;
                        round_cnt  <= '0;
                        done       <= 1'b1;
                        ciphertext <= round_out;
                    end else begin
                        round_cnt <= round_cnt + 4'd1;
                    end
                end
                CTRL_DONE: begin
                    // ciphertext holds until the next done
                    ctrl_q <= CTRL_IDLE;
                end
                default: begin
                    ctrl_q    <= CTRL_IDLE;
                    round_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: aes_core_asserts.sv
// aes core handshake assertions
`timescale 1ns/1ps
`default_nettype none

module aes_core_asserts (
    input logic                clk,
    input logic                reset,
    input logic                load,
    input logic                done,
    input aes_pkg::aes_block_t ciphertext,
    input aes_pkg::aes_ctrl_t  ctrl_q
);

    import aes_pkg::*;

    // accepted load edge to the edge that samples done high
    localparam int LOAD_TO_DONE = AES_NUM_ROUNDS + 1;

    // a load only counts while idle
    logic accepted;

    assign accepted = load && (ctrl_q == CTRL_IDLE);

    //////////////////////////////
    // handshake
    //////////////////////////////

    // done is a one cycle strobe
    a_done_single: assert property (@(posedge clk) disable iff (!reset)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // every accepted load ends in done after the fixed latency
    a_done_latency: assert property (@(posedge clk) disable iff (!reset)
        accepted |-> ##LOAD_TO_DONE done)
        else $error("done missing after an accepted load");

    // result register only moves at the end of a run
    a_ct_idle_stable: assert property (@(posedge clk) disable iff (!reset)
        (ctrl_q == CTRL_IDLE) |=> $stable(ciphertext))
        else $error("ciphertext changed while idle");

endmodule

`default_nettype wire

// File: tb_aes_core.sv
// aes-128 core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_aes_core;

    import aes_pkg::*;

    // known answer vectors in the table
    localparam int NUM_VECTORS = 3;
    // load driven on a falling edge, done seen this many falling edges later
    localparam int LOAD_TO_DONE = 11;
    // bound on every wait for done
    localparam int DONE_TIMEOUT = 20;
    // cycle of the dropped load in the busy test
    localparam int BUSY_CYCLE = 4;

    logic       clk;
    logic       reset;
    logic       load;
    aes_block_t key;
    aes_block_t plaintext;
    logic       done;
    aes_block_t ciphertext;

    // key, plaintext and expected ciphertext per row
    aes_block_t vec_key [NUM_VECTORS];
    aes_block_t vec_pt  [NUM_VECTORS];
    aes_block_t vec_ct  [NUM_VECTORS];

    int error_count;
    int timeout_count;

    //////////////////////////////
    // DUT and checkers
    //////////////////////////////

    aes_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .key       (key),
        .plaintext (plaintext),
        .done      (done),
        .ciphertext(ciphertext)
    );

    bind aes_core aes_core_asserts u_asserts (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .done      (done),
        .ciphertext(ciphertext),
        .ctrl_q    (ctrl_q)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // FIPS-197 appendix vectors plus the all-zero case
    task automatic fill_table();
        vec_key[0] = 128'h000102030405060708090a0b0c0d0e0f;
        vec_pt[0]  = 128'h00112233445566778899aabbccddeeff;
        vec_ct[0]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        vec_key[1] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        vec_pt[1]  = 128'h3243f6a8885a308d313198a2e0370734;
        vec_ct[1]  = 128'h3925841d02dc09fbdc118597196a0b32;
        vec_key[2] = 128'h00000000000000000000000000000000;
        vec_pt[2]  = 128'h00000000000000000000000000000000;
        vec_ct[2]  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    endtask

    task automatic check_block(input string name, input aes_block_t got,
                               input aes_block_t exp);
        if (got !== exp) begin
            $display("** Error %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // counts falling edges from the load until done is seen
    // busy_cycle > 0 strobes a second load with other data at that cycle
    task automatic wait_done(input int busy_cycle, output int latency, output bit seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // load is high for one rising edge only
            load = (cycles == busy_cycle);
            if (cycles == busy_cycle) begin
                key       = ~key;
                plaintext = ~plaintext;
            end
            seen = done;
        end
        latency = cycles;
        if (!seen) begin
            $display("done never asserted within %0d cycles", DONE_TIMEOUT);
            timeout_count++;
        end
    endtask

    // one encryption from table row idx, called right after a falling edge
    task automatic run_vector(input int idx, input int busy_cycle);
        int latency;
        bit seen;
        key       = vec_key[idx];
        plaintext = vec_pt[idx];
        load      = 1'b1;
        wait_done(busy_cycle, latency, seen);
        if (seen) begin
            check_count("latency", latency, LOAD_TO_DONE);
            check_block("ciphertext", ciphertext, vec_ct[idx]);
            // strobe drops after one cycle, result stays
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_block("ciphertext", ciphertext, vec_ct[idx]);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        clk           = 1'b0;
        reset         = 1'b0;
        load          = 1'b0;
        key           = '0;
        plaintext     = '0;
        error_count   = 0;
        timeout_count = 0;
        fill_table();

        // reset low for 10 cycles
        repeat (10) @(negedge clk);
        reset = 1'b1;

        // idle outputs after reset
        repeat (5) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_block("ciphertext", ciphertext, '0);
        end

        // known answers, each followed by a few idle cycles
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i, 0);
            repeat (3) begin
                @(negedge clk);
                check_bit("done", done, 1'b0);
                check_block("ciphertext", ciphertext, vec_ct[i]);
            end
        end

        // second load while busy is dropped
        run_vector(1, BUSY_CYCLE);
        for (int c = 0; c < DONE_TIMEOUT; c++) begin
            @(negedge clk);
            if (done) begin
                $display("extra done seen after a dropped load");
                error_count++;
            end
            check_block("ciphertext", ciphertext, vec_ct[1]);
        end

        // back to back, each load in the cycle after the previous done
        run_vector(2, 0);
        run_vector(0, 0);
        run_vector(1, 0);

        repeat (2) @(negedge clk);
        $display("summary %0d mismatches %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: aes_core.f
aes_pkg.sv
aes_sbox.sv
aes_key_schedule.sv
aes_round.sv
aes_core.sv
aes_core_asserts.sv
tb_aes_core.sv
